//--- src/pool_config.svh
/*
 * Build-time sizing of the pooling stage
 * map_beat_t carries POOL_NUM_CORES indices, so the global buffer
 * word must be widened together with the core count
 * POOL_NUM_CORES must be at least 2 for the one-bit core tag
 */
`ifndef POOL_CONFIG_SVH
`define POOL_CONFIG_SVH

// Core count and row geometry
`define POOL_NUM_CORES 2
`define POOL_LANES     4
`define POOL_ACT_W     8

// Index and counter widths
`define POOL_IDX_W     8
`define POOL_K_W       4
`define POOL_PNT_W     8

`endif

//--- src/pool_cfg_pkg.sv
/*
 * Configuration and control types of a pooling run
 * Nip must be a multiple of POOL_NUM_CORES and K at least 1
 */
`default_nettype none

`include "pool_config.svh"

package pool_cfg_pkg;

    // One run, K neighbours per point and Nip points in total
    typedef struct packed {
        logic [`POOL_K_W-1:0]   k;
        logic [`POOL_PNT_W-1:0] nip;
    } pool_cfg_t;

    // Tag of a core on the shared ports
    typedef logic [$clog2(`POOL_NUM_CORES)-1:0] core_id_t;

    // Control FSM of the stage
    typedef enum logic [1:0] {
        RUN_IDLE,
        RUN_MAP,
        RUN_WAIT
    } run_state_t;

    // Per-core FSM, one index in flight at a time
    typedef enum logic [1:0] {
        CORE_IDX,
        CORE_REQ,
        CORE_RSP,
        CORE_RES
    } core_state_t;

endpackage

`default_nettype wire

//--- src/pool_data_pkg.sv
/*
 * Data types moved between buffer, cores and result port
 * Lanes are unsigned, lane 0 sits in the low bits of a row
 */
`default_nettype none

`include "pool_config.svh"

package pool_data_pkg;

    typedef logic [`POOL_ACT_W-1:0] act_t;
    typedef logic [`POOL_IDX_W-1:0] idx_t;

    // One feature row, all lanes
    typedef act_t [`POOL_LANES-1:0] feat_row_t;

    // Map beat, entry c belongs to core c
    typedef idx_t [`POOL_NUM_CORES-1:0] map_beat_t;

    // Row fetch from one core
    typedef struct packed {
        pool_cfg_pkg::core_id_t core_id;
        idx_t                   addr;
    } fetch_req_t;

    // Returned row, tagged with the asking core
    typedef struct packed {
        pool_cfg_pkg::core_id_t core_id;
        feat_row_t              row;
    } fetch_rsp_t;

    // Pooled row, pnt counts points within its core
    typedef struct packed {
        pool_cfg_pkg::core_id_t   core_id;
        logic [`POOL_PNT_W-1:0]   pnt;
        feat_row_t                row;
    } pool_result_t;

endpackage

`default_nettype wire

//--- src/prio_merge.sv
/*
 * Fixed-priority merge of N valid/ready senders onto one port
 * Requester 0 wins, grant is purely combinational
 * A sender keeps valid up until its transfer, so grants never drop payload
 */
`timescale 1ns/1ps
`default_nettype none

module prio_merge #(
    parameter int  N = 2,
    parameter type payload_t = logic
) (
    input  wire [N-1:0] valid_in,
    input  wire payload_t data_in [N],
    output logic [N-1:0] ready_in,
    output logic        valid_out,
    output payload_t    data_out,
    input  wire         ready_out
);
    logic [N-1:0] grant;

    // Lowest set bit of the valid vector
    assign grant = valid_in & (~valid_in + 1'b1);

    assign valid_out = |valid_in;

    // Ready goes back only to the granted sender
    assign ready_in = grant & {N{ready_out}};

    always_comb begin
        data_out = data_in[0];
        for (int i = 0; i < N; i++) begin
            if (grant[i]) begin
                data_out = data_in[i];
            end
        end
    end

endmodule

`default_nettype wire

//--- src/pool_ctrl.sv
/*
 * Run control of the pooling stage
 * Configuration is taken only while idle and held for the whole run
 * clear aborts at once, cores are emptied through run
 */
`timescale 1ns/1ps
`default_nettype none

`include "pool_config.svh"

module pool_ctrl (
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire                             clear,
    input  wire                             cfg_valid,
    input  wire pool_cfg_pkg::pool_cfg_t    cfg,
    output logic                            cfg_ready,
    input  wire                             map_valid,
    output logic                            map_ready,
    input  wire [`POOL_NUM_CORES-1:0]       idx_ready,
    input  wire                             res_valid,
    input  wire                             res_ready,
    output logic                            run,
    output logic [`POOL_K_W-1:0]            k
);
    import pool_cfg_pkg::*;

    localparam int CNT_W = `POOL_K_W + `POOL_PNT_W;
    localparam logic [`POOL_PNT_W-1:0] NC = `POOL_PNT_W'(`POOL_NUM_CORES);

    run_state_t             state;
    run_state_t             state_nxt;
    pool_cfg_t              cfg_r;
    logic [CNT_W-1:0]       map_cnt;
    logic [CNT_W-1:0]       map_total;
    logic [`POOL_PNT_W-1:0] res_cnt;
    logic                   cfg_fire;
    logic                   map_fire;
    logic                   res_fire;
    logic                   map_last;
    logic                   res_last;

    // ========================================================
    // Handshakes
    // ========================================================
    assign cfg_ready = (state == RUN_IDLE);
    // Beat goes to all cores at once, so every core must be open
    assign map_ready = (state == RUN_MAP) & (&idx_ready);
    assign cfg_fire  = cfg_valid & cfg_ready;
    assign map_fire  = map_valid & map_ready;
    assign res_fire  = res_valid & res_ready;

    assign run = (state != RUN_IDLE);
    assign k   = cfg_r.k;

    // Beats per run, each beat feeds every core once
    assign map_total = cfg_r.k * (cfg_r.nip / NC);
    assign map_last  = map_fire & ((map_cnt + 1'b1) == map_total);
    assign res_last  = res_fire & ((res_cnt + 1'b1) == cfg_r.nip);

    // ========================================================
    // Run FSM
    // ========================================================
    always_comb begin
        state_nxt = state;
        case (state)
            RUN_IDLE: if (cfg_fire) state_nxt = RUN_MAP;
            RUN_MAP:  if (map_last) state_nxt = RUN_WAIT;
            RUN_WAIT: if (res_last) state_nxt = RUN_IDLE;
            default:  state_nxt = RUN_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= RUN_IDLE;
        end else if (clear) begin
            state <= RUN_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Held configuration
    always_ff @(posedge clk) begin
        if (cfg_fire) begin
            cfg_r <= cfg;
        end
    end

    // Transfer counters, reloaded every idle cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            map_cnt <= '0;
            res_cnt <= '0;
        end else if (state == RUN_IDLE) begin
            map_cnt <= '0;
            res_cnt <= '0;
        end else begin
            if (map_fire) begin
                map_cnt <= map_cnt + 1'b1;
            end
            // Results can already leave during map intake
            if (res_fire) begin
                res_cnt <= res_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/pool_core.sv
/*
 * One pooling core, lane-wise unsigned max over K fetched rows
 * Single outstanding fetch, so the response needs no ready
 * Responses tagged for other cores are ignored
 * run low empties the core and restarts point numbering
 */
`timescale 1ns/1ps
`default_nettype none

`include "pool_config.svh"

module pool_core #(
    parameter pool_cfg_pkg::core_id_t CORE_ID = '0
) (
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire                             run,
    input  wire [`POOL_K_W-1:0]             k,
    input  wire                             idx_valid,
    input  wire [`POOL_IDX_W-1:0]           idx,
    output logic                            idx_ready,
    output logic                            req_valid,
    output pool_data_pkg::fetch_req_t       req,
    input  wire                             req_ready,
    input  wire                             rsp_valid,
    input  wire pool_data_pkg::fetch_rsp_t  rsp,
    output logic                            res_valid,
    output pool_data_pkg::pool_result_t     res,
    input  wire                             res_ready
);
    import pool_cfg_pkg::*;
    import pool_data_pkg::*;

    core_state_t            state;
    logic [`POOL_K_W-1:0]   nbr_cnt;
    logic [`POOL_PNT_W-1:0] pnt_cnt;
    logic [`POOL_IDX_W-1:0] addr_r;
    feat_row_t              acc;
    feat_row_t              acc_nxt;
    logic                   idx_fire;
    logic                   rsp_hit;
    logic                   res_fire;
    logic                   nbr_last;

    // ========================================================
    // Handshakes
    // ========================================================
    assign idx_ready = run & (state == CORE_IDX);
    assign req_valid = run & (state == CORE_REQ);
    assign res_valid = run & (state == CORE_RES);

    assign idx_fire = idx_valid & idx_ready;
    assign res_fire = res_valid & res_ready;
    // Only our own tag, and only while waiting for it
    assign rsp_hit  = rsp_valid & (rsp.core_id == CORE_ID) & (state == CORE_RSP);
    assign nbr_last = ((nbr_cnt + 1'b1) == k);

    assign req.core_id = CORE_ID;
    assign req.addr    = addr_r;

    assign res.core_id = CORE_ID;
    assign res.pnt     = pnt_cnt;
    assign res.row     = acc;

    // Lane-wise max of the running row and the fetched one
    always_comb begin
        for (int l = 0; l < `POOL_LANES; l++) begin
            acc_nxt[l] = (rsp.row[l] > acc[l]) ? rsp.row[l] : acc[l];
        end
    end

    // ========================================================
    // Core FSM and counters
    // ========================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= CORE_IDX;
            nbr_cnt <= '0;
            pnt_cnt <= '0;
        end else if (!run) begin
            state   <= CORE_IDX;
            nbr_cnt <= '0;
            pnt_cnt <= '0;
        end else begin
            case (state)
                CORE_IDX: if (idx_fire) state <= CORE_REQ;
                // Wait for the merge grant
                CORE_REQ: if (req_ready) state <= CORE_RSP;
                CORE_RSP: begin
                    if (rsp_hit) begin
                        if (nbr_last) begin
                            state   <= CORE_RES;
                            nbr_cnt <= '0;
                        end else begin
                            state   <= CORE_IDX;
                            nbr_cnt <= nbr_cnt + 1'b1;
                        end
                    end
                end
                // Index intake stays closed until the row is taken
                CORE_RES: begin
                    if (res_fire) begin
                        state   <= CORE_IDX;
                        pnt_cnt <= pnt_cnt + 1'b1;
                    end
                end
                default: state <= CORE_IDX;
            endcase
        end
    end

    // Running max restarts from zero for every point
    always_ff @(posedge clk) begin
        if (!run) begin
            acc <= '0;
        end else if (rsp_hit) begin
            acc <= acc_nxt;
        end else if (res_fire) begin
            acc <= '0;
        end
        if (idx_fire) begin
            addr_r <= idx;
        end
    end

endmodule

`default_nettype wire

//--- src/pool_top.sv
/*
 * Pooling stage top, control plus POOL_NUM_CORES cores
 * Fetch requests and results share one port each, lower core first
 * Fetch responses are broadcast and must return the request's core tag
 */
`timescale 1ns/1ps
`default_nettype none

`include "pool_config.svh"

module pool_top (
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire                             clear,
    input  wire                             cfg_valid,
    input  wire pool_cfg_pkg::pool_cfg_t    cfg,
    output logic                            cfg_ready,
    input  wire                             map_valid,
    input  wire pool_data_pkg::map_beat_t   map,
    output logic                            map_ready,
    output logic                            mem_req_valid,
    output pool_data_pkg::fetch_req_t       mem_req,
    input  wire                             mem_req_ready,
    input  wire                             mem_rsp_valid,
    input  wire pool_data_pkg::fetch_rsp_t  mem_rsp,
    output logic                            res_valid,
    output pool_data_pkg::pool_result_t     res,
    input  wire                             res_ready
);
    import pool_cfg_pkg::*;
    import pool_data_pkg::*;

    localparam int NC = `POOL_NUM_CORES;

    logic                 run;
    logic [`POOL_K_W-1:0] k;
    logic                 map_fire;
    logic [NC-1:0]        idx_ready;
    logic [NC-1:0]        core_req_valid;
    logic [NC-1:0]        core_req_ready;
    logic [NC-1:0]        core_res_valid;
    logic [NC-1:0]        core_res_ready;
    fetch_req_t           core_req [NC];
    pool_result_t         core_res [NC];

    // ========================================================
    // Control
    // ========================================================
    pool_ctrl u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .clear     (clear),
        .cfg_valid (cfg_valid),
        .cfg       (cfg),
        .cfg_ready (cfg_ready),
        .map_valid (map_valid),
        .map_ready (map_ready),
        .idx_ready (idx_ready),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .run       (run),
        .k         (k)
    );

    // One beat feeds all cores in the same cycle
    assign map_fire = map_valid & map_ready;

    // ========================================================
    // Cores
    // ========================================================
    for (genvar c = 0; c < NC; c++) begin : g_core
        pool_core #(
            .CORE_ID (core_id_t'(c))
        ) u_core (
            .clk       (clk),
            .rst_n     (rst_n),
            .run       (run),
            .k         (k),
            .idx_valid (map_fire),
            .idx       (map[c]),
            .idx_ready (idx_ready[c]),
            .req_valid (core_req_valid[c]),
            .req       (core_req[c]),
            .req_ready (core_req_ready[c]),
            .rsp_valid (mem_rsp_valid),
            .rsp       (mem_rsp),
            .res_valid (core_res_valid[c]),
            .res       (core_res[c]),
            .res_ready (core_res_ready[c])
        );
    end

    // ========================================================
    // Shared ports
    // ========================================================
    prio_merge #(
        .N         (NC),
        .payload_t (fetch_req_t)
    ) u_req_merge (
        .valid_in  (core_req_valid),
        .data_in   (core_req),
        .ready_in  (core_req_ready),
        .valid_out (mem_req_valid),
        .data_out  (mem_req),
        .ready_out (mem_req_ready)
    );

    prio_merge #(
        .N         (NC),
        .payload_t (pool_result_t)
    ) u_res_merge (
        .valid_in  (core_res_valid),
        .data_in   (core_res),
        .ready_in  (core_res_ready),
        .valid_out (res_valid),
        .data_out  (res),
        .ready_out (res_ready)
    );

endmodule

`default_nettype wire

//--- dv/feature_mem_model.sv
/*
 * Behavioural feature buffer, simulation only
 * Serves one request at a time, answers 1 to 4 cycles after the transfer
 * Lane j of row a holds (a*37 + j*91 + 5) mod 256
 * Latency comes from a 32-bit Fibonacci LFSR, seed 32'hf574
 */
`timescale 1ns/1ps
`default_nettype none

`include "pool_config.svh"

module feature_mem_model (
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire                             req_valid,
    input  wire pool_data_pkg::fetch_req_t  req,
    output logic                            req_ready,
    output logic                            rsp_valid,
    output pool_data_pkg::fetch_rsp_t       rsp
);
    import pool_data_pkg::*;

    logic [31:0] lfsr;
    logic [31:0] lfsr_a;
    logic [31:0] lfsr_b;
    logic        busy;
    logic [1:0]  wait_cnt;
    fetch_req_t  held;

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic feat_row_t row_at(input idx_t a);
        feat_row_t row;
        int        ai;
        ai = a;
        for (int j = 0; j < `POOL_LANES; j++) begin
            row[j] = act_t'((ai * 37 + j * 91 + 5) % 256);
        end
        return row;
    endfunction

    // Two steps per request, one bit each for the latency
    assign lfsr_a    = lfsr_step(lfsr);
    assign lfsr_b    = lfsr_step(lfsr_a);
    assign req_ready = !busy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lfsr      <= 32'hf574;
            busy      <= 1'b0;
            wait_cnt  <= '0;
            held      <= '0;
            rsp_valid <= 1'b0;
            rsp       <= '0;
        end else begin
            rsp_valid <= 1'b0;
            if (!busy) begin
                if (req_valid) begin
                    busy     <= 1'b1;
                    held     <= req;
                    wait_cnt <= {lfsr_a[0], lfsr_b[0]};
                    lfsr     <= lfsr_b;
                end
            end else if (wait_cnt == 2'd0) begin
                // Response carries the tag of the asking core
                busy        <= 1'b0;
                rsp_valid   <= 1'b1;
                rsp.core_id <= held.core_id;
                rsp.row     <= row_at(held.addr);
            end else begin
                wait_cnt <= wait_cnt - 2'd1;
            end
        end
    end

endmodule

`default_nettype wire

//--- dv/tb_pool_top.sv
/*
 * Directed tests of the pooling stage, stops at the first error
 * Random indices and result stalls come from an LFSR, seed 32'hf574
 * Results are matched per core and point number, cross-core order is free
 */
`timescale 1ns/1ps
`default_nettype none

`include "pool_config.svh"

module tb_pool_top;
    import pool_cfg_pkg::*;
    import pool_data_pkg::*;

    localparam int NC             = `POOL_NUM_CORES;
    localparam int MAX_LAT        = 4;
    // Beats over all tests, the clear test sends 3 then 4
    localparam int TOTAL_BEATS    = 2 + 12 + 12 + 3 + 4;
    localparam int BEAT_CYCLES    = NC * (MAX_LAT + 3) + 4;
    localparam int TIMEOUT_CYCLES = TOTAL_BEATS * BEAT_CYCLES * 4 + 200;

    logic         clk;
    logic         rst_n;
    logic         clear;
    logic         cfg_valid;
    pool_cfg_t    cfg;
    logic         cfg_ready;
    logic         map_valid;
    map_beat_t    map;
    logic         map_ready;
    logic         mem_req_valid;
    fetch_req_t   mem_req;
    logic         mem_req_ready;
    logic         mem_rsp_valid;
    fetch_rsp_t   mem_rsp;
    logic         res_valid;
    pool_result_t res;
    logic         res_ready;

    logic [31:0]  lfsr_state;
    int           cycles;
    int           cur_k;
    map_beat_t    beats [$];

    pool_top i_pool_top (
        .clk           (clk),
        .rst_n         (rst_n),
        .clear         (clear),
        .cfg_valid     (cfg_valid),
        .cfg           (cfg),
        .cfg_ready     (cfg_ready),
        .map_valid     (map_valid),
        .map           (map),
        .map_ready     (map_ready),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp       (mem_rsp),
        .res_valid     (res_valid),
        .res           (res),
        .res_ready     (res_ready)
    );

    feature_mem_model u_mem (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (mem_req_valid),
        .req       (mem_req),
        .req_ready (mem_req_ready),
        .rsp_valid (mem_rsp_valid),
        .rsp       (mem_rsp)
    );

    always #4 clk = ~clk;

    // ========================================================
    // Helpers
    // ========================================================
    task automatic fail(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1);
    endtask

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per bit taken
    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    // Buffer contents by rule
    function automatic feat_row_t mem_row(input idx_t a);
        feat_row_t row;
        int        ai;
        ai = a;
        for (int j = 0; j < `POOL_LANES; j++) begin
            row[j] = act_t'((ai * 37 + j * 91 + 5) % 256);
        end
        return row;
    endfunction

    // Point p of core c pools the core-c lanes of beats p*K .. p*K+K-1
    function automatic feat_row_t expected_row(input core_id_t c,
                                               input logic [`POOL_PNT_W-1:0] p);
        feat_row_t acc;
        feat_row_t row;
        int        base;
        acc  = '0;
        base = p;
        base = base * cur_k;
        for (int n = 0; n < cur_k; n++) begin
            row = mem_row(beats[base + n][c]);
            for (int j = 0; j < `POOL_LANES; j++) begin
                if (row[j] > acc[j]) acc[j] = row[j];
            end
        end
        return acc;
    endfunction

    // ========================================================
    // Compare tasks
    // ========================================================
    task automatic compare_ready(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            fail($sformatf("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    task automatic compare_point(input core_id_t id, input logic [`POOL_PNT_W-1:0] got,
                                 input logic [`POOL_PNT_W-1:0] exp);
        if (got !== exp) begin
            fail($sformatf("Mismatch at %0t: core %0d point number %0d, expected %0d",
                           $time, id, got, exp));
        end
    endtask

    task automatic compare_row(input core_id_t id, input logic [`POOL_PNT_W-1:0] pnt,
                               input feat_row_t got, input feat_row_t exp);
        if (got !== exp) begin
            fail($sformatf("Mismatch at %0t: core %0d point %0d row %h, expected %h",
                           $time, id, pnt, got, exp));
        end
    endtask

    // ========================================================
    // Drivers and monitors, entered right after a rising edge
    // ========================================================
    task automatic make_beats(input int n, input bit random_idx);
        map_beat_t   beat;
        logic [31:0] r;
        beats.delete();
        for (int b = 0; b < n; b++) begin
            for (int c = 0; c < NC; c++) begin
                if (random_idx) begin
                    draw_bits(8, r);
                    beat[c] = r[7:0];
                end else begin
                    beat[c] = idx_t'(b * 16 + c * 5 + 3);
                end
            end
            beats.push_back(beat);
        end
    endtask

    task automatic configure(input int k, input int nip);
        pool_cfg_t word;
        word.k    = k[`POOL_K_W-1:0];
        word.nip  = nip[`POOL_PNT_W-1:0];
        cur_k     = k;
        cfg_valid <= 1'b1;
        cfg       <= word;
        do @(posedge clk); while (!cfg_ready);
        cfg_valid <= 1'b0;
        @(posedge clk);
        compare_ready("cfg_ready after configuration", cfg_ready, 1'b0);
    endtask

    task automatic send_beats(input int n);
        for (int b = 0; b < n; b++) begin
            map_valid <= 1'b1;
            map       <= beats[b];
            do @(posedge clk); while (!map_ready);
        end
        map_valid <= 1'b0;
    endtask

    task automatic collect_results(input int nip, input bit stall);
        int          got;
        int          per_core [NC];
        logic [31:0] r;
        got = 0;
        for (int c = 0; c < NC; c++) per_core[c] = 0;
        while (got < nip) begin
            if (stall) begin
                // Ready in about one cycle out of four
                draw_bits(2, r);
                res_ready <= (r[1:0] == 2'b00);
            end else begin
                res_ready <= 1'b1;
            end
            @(posedge clk);
            compare_ready("cfg_ready during run", cfg_ready, 1'b0);
            if (res_valid && res_ready) begin
                if (per_core[res.core_id] >= nip / NC) begin
                    fail($sformatf("Core %0d delivered more points than configured",
                                   res.core_id));
                end
                compare_point(res.core_id, res.pnt, per_core[res.core_id]);
                compare_row(res.core_id, res.pnt, res.row,
                            expected_row(res.core_id, res.pnt));
                per_core[res.core_id]++;
                got++;
            end
        end
        res_ready <= 1'b0;
        @(posedge clk);
        compare_ready("cfg_ready after last result", cfg_ready, 1'b1);
        compare_ready("res_valid after last result", res_valid, 1'b0);
    endtask

    task automatic run_pool(input int k, input int nip, input bit random_idx,
                            input bit stall);
        make_beats(k * nip / NC, random_idx);
        configure(k, nip);
        fork
            send_beats(k * nip / NC);
            collect_results(nip, stall);
        join
    endtask

    // ========================================================
    // Directed tests
    // ========================================================
    task automatic test_single_neighbour();
        $display("Test: K=1, Nip=4, fixed indices");
        run_pool(1, 4, 1'b0, 1'b0);
    endtask

    task automatic test_max_pool();
        $display("Test: K=4, Nip=6, random indices");
        run_pool(4, 6, 1'b1, 1'b0);
    endtask

    task automatic test_backpressure();
        $display("Test: K=4, Nip=6, result port stalls");
        run_pool(4, 6, 1'b1, 1'b1);
    endtask

    task automatic test_clear_restart();
        $display("Test: clear in the middle of a run");
        make_beats(12, 1'b1);
        configure(4, 6);
        send_beats(3);
        clear <= 1'b1;
        @(posedge clk);
        clear <= 1'b0;
        @(posedge clk);
        compare_ready("cfg_ready after clear", cfg_ready, 1'b1);
        // A stale fetch may still be in the buffer when the new run starts
        run_pool(2, 4, 1'b1, 1'b0);
    endtask

    // Run limit from beat count and worst fetch latency
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            fail($sformatf("Timeout after %0d cycles, DUT stopped responding", cycles));
        end
    end

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        clear      = 1'b0;
        cfg_valid  = 1'b0;
        cfg        = '0;
        map_valid  = 1'b0;
        map        = '0;
        res_ready  = 1'b0;
        lfsr_state = 32'hf574;
        cycles     = 0;
        cur_k      = 0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        compare_ready("cfg_ready after reset", cfg_ready, 1'b1);
        compare_ready("map_ready after reset", map_ready, 1'b0);
        compare_ready("mem_req_valid after reset", mem_req_valid, 1'b0);
        compare_ready("res_valid after reset", res_valid, 1'b0);
        test_single_neighbour();
        test_max_pool();
        test_backpressure();
        test_clear_restart();
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+src
src/pool_cfg_pkg.sv
src/pool_data_pkg.sv
src/prio_merge.sv
src/pool_ctrl.sv
src/pool_core.sv
src/pool_top.sv
dv/feature_mem_model.sv
dv/tb_pool_top.sv

//--- Makefile
# Verilator build and run of the pooling stage testbench

SIM      := verilator
FLAGS    := --binary --timing --timescale 1ns/1ps
TOP      := tb_pool_top
FILELIST := files.f
LOG      := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "TB PASSED" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
